//--- Bender.yml
package:
  name: arp_tx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/eth_pkg.sv
      - verilog/phy_pkg.sv
      - verilog/crc32_eth.sv
      - verilog/arp_frame_seq.sv
      - verilog/rgmii_ddr_tx.sv
      - verilog/arp_tx_top.sv
  - target: test
    include_dirs:
      - include
      - tests
    files:
      - tests/arp_tx_tb.sv

//--- arp_tx_top.f
+incdir+include
+incdir+tests
verilog/eth_pkg.sv
verilog/phy_pkg.sv
verilog/crc32_eth.sv
verilog/arp_frame_seq.sv
verilog/rgmii_ddr_tx.sv
verilog/arp_tx_top.sv
tests/arp_tx_tb.sv

//--- include/arp_tx_consts.svh
`ifndef ARP_TX_CONSTS_SVH
`define ARP_TX_CONSTS_SVH

// frame layout in bytes
`define ARP_PREAMBLE_BYTES 7
`define ARP_PAD_BYTES      18
`define ARP_FRAME_BYTES    72   // preamble through fcs

// field values
`define ARP_PREAMBLE  8'h55
`define ARP_SFD       8'hD5
`define ARP_ETHERTYPE 16'h0806
`define ARP_HTYPE     16'h0001  // ethernet
`define ARP_PTYPE     16'h0800  // ipv4
`define ARP_HLEN      8'd6
`define ARP_PLEN      8'd4
`define ARP_OPER_REQ  16'h0001

`define ARP_GAP_DEFAULT 125000  // idle cycles between frames

`endif

//--- tests/arp_tx_ref.svh
`ifndef ARP_TX_REF_SVH
`define ARP_TX_REF_SVH

// bit-serial reflected crc-32 taking one data bit per step
function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
  logic [31:0] c;
  logic        fb;
  c = crc;
  for (int k = 0; k < 8; k++)
  begin
    fb = c[0] ^ b[k];
    c  = c >> 1;
    if (fb)
      c = c ^ 32'hEDB8_8320;
  end
  return c;
endfunction

// byte k of the frame sits at [8*k +: 8]
function automatic logic [8*`ARP_FRAME_BYTES-1:0] expected_frame(
  input eth_pkg::mac_addr_t  mac,
  input eth_pkg::ipv4_addr_t sip,
  input eth_pkg::ipv4_addr_t dip
);
  logic [8*`ARP_FRAME_BYTES-1:0] f;
  logic [8*42-1:0]               hdr;  // first byte on top
  logic [31:0]                   crc;
  logic [7:0]                    b;
  int                            n;
  f = '0;
  for (int i = 0; i < `ARP_PREAMBLE_BYTES; i++)
    f[8*i +: 8] = `ARP_PREAMBLE;
  f[8*`ARP_PREAMBLE_BYTES +: 8] = `ARP_SFD;
  hdr = {48'hFFFF_FFFF_FFFF, mac, `ARP_ETHERTYPE, `ARP_HTYPE, `ARP_PTYPE, `ARP_HLEN,
         `ARP_PLEN, `ARP_OPER_REQ, mac, sip, 48'h0, dip};
  n   = `ARP_PREAMBLE_BYTES + 1;
  crc = '1;
  for (int i = 0; i < 42; i++)
  begin
    b = hdr[8*(41-i) +: 8];
    f[8*(n+i) +: 8] = b;
    crc = crc32_update(crc, b);
  end
  for (int i = 0; i < `ARP_PAD_BYTES; i++)
    crc = crc32_update(crc, 8'h00);  // padding already zero in f
  crc = ~crc;
  n   = n + 42 + `ARP_PAD_BYTES;
  for (int i = 0; i < 4; i++)
    f[8*(n+i) +: 8] = crc[8*i +: 8];  // fcs low byte first
  return f;
endfunction

`endif

//--- tests/arp_tx_tb.sv
`timescale 1ns/1ps

`include "arp_tx_consts.svh"

module arp_tx_tb;

  localparam int gap_len       = 20;
  localparam int frame_len     = `ARP_FRAME_BYTES;
  localparam int frame_timeout = 400;

  logic                tx_clk;
  logic                rst_n;
  logic                enable;
  eth_pkg::mac_addr_t  src_mac;
  eth_pkg::ipv4_addr_t src_ip;
  eth_pkg::ipv4_addr_t dst_ip;
  phy_pkg::nibble_t    txd;
  logic                tx_ctl;

  phy_pkg::byte_t rx_q[$];   // bytes rebuilt from txd
  phy_pkg::byte_t exp_q[$];
  int             run_q[$];  // tx_ctl high run per frame
  int             gap_q[$];  // tx_ctl low run before each later frame
  int             errors = 0;
  int             checks = 0;
  int             seed   = 32'h3849_c879;

  `include "arp_tx_ref.svh"

  arp_tx_top #(
    .gap_cycles (gap_len)
  ) uut (
    .tx_clk  (tx_clk),
    .rst_n   (rst_n),
    .enable  (enable),
    .src_mac (src_mac),
    .src_ip  (src_ip),
    .dst_ip  (dst_ip),
    .txd     (txd),
    .tx_ctl  (tx_ctl)
  );

  initial
  begin
    tx_clk = 1'b0;
    forever #2 tx_clk = ~tx_clk;
  end

  // **************************************************
  // helpers
  // **************************************************
  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", what, expected, actual);
    end
  endtask

  function automatic eth_pkg::arp_field_e field_at(input int idx);
    if (idx < 7)       return eth_pkg::st_preamble;
    else if (idx < 8)  return eth_pkg::st_sfd;
    else if (idx < 14) return eth_pkg::st_dst_mac;
    else if (idx < 20) return eth_pkg::st_src_mac;
    else if (idx < 22) return eth_pkg::st_ethertype;
    else if (idx < 30) return eth_pkg::st_arp_hdr;
    else if (idx < 36) return eth_pkg::st_sender_hw;
    else if (idx < 40) return eth_pkg::st_sender_ip;
    else if (idx < 46) return eth_pkg::st_target_hw;
    else if (idx < 50) return eth_pkg::st_target_ip;
    else if (idx < 68) return eth_pkg::st_pad;
    return eth_pkg::st_fcs;
  endfunction

  task automatic next_cycle();
    @(posedge tx_clk);
    #1;
  endtask

  task automatic queue_frame();
    logic [8*`ARP_FRAME_BYTES-1:0] f;
    f = expected_frame(src_mac, src_ip, dst_ip);
    for (int i = 0; i < frame_len; i++)
      exp_q.push_back(f[8*i +: 8]);
  endtask

  task automatic wait_frames(input int count, input string what);
    int n;
    n = 0;
    while ((run_q.size() < count || rx_q.size() != 0) && n < frame_timeout)
    begin
      next_cycle();
      n++;
    end
    if (run_q.size() < count || rx_q.size() != 0)
    begin
      errors++;
      $display("timed out after %0d cycles waiting for %s", n, what);
    end
  endtask

  task automatic wait_tx_start();
    int n;
    n = 0;
    while (tx_ctl !== 1'b1 && n < frame_timeout)
    begin
      next_cycle();
      n++;
    end
    if (tx_ctl !== 1'b1)
    begin
      errors++;
      $display("timed out after %0d cycles waiting for tx_ctl to rise", n);
    end
  endtask

  task automatic count_high(input int cycles, output int high);
    high = 0;
    repeat (cycles)
    begin
      next_cycle();
      if (tx_ctl !== 1'b0)
        high++;
    end
  endtask

  task automatic check_runs(input int from);
    for (int i = from; i < run_q.size(); i++)
      check_value($sformatf("tx_ctl high cycles, frame %0d", i), frame_len, run_q[i]);
  endtask

  task automatic report_test(input int num, input string title, input int err_start);
    $display("test %0d %s: %0d errors", num, title, errors - err_start);
  endtask

  // **************************************************
  // ddr capture with the low nibble in the high phase
  // **************************************************
  initial
  begin
    phy_pkg::nibble_t lo;
    logic             in_frame;
    logic             seen_frame;
    int               run_len;
    int               gap_cnt;
    in_frame   = 1'b0;
    seen_frame = 1'b0;
    run_len    = 0;
    gap_cnt    = 0;
    forever
    begin
      @(posedge tx_clk);
      #0.5;
      if (tx_ctl === 1'b1)
      begin
        if (!in_frame)
        begin
          if (seen_frame)
            gap_q.push_back(gap_cnt);
          in_frame = 1'b1;
          run_len  = 0;
        end
        run_len++;
        lo = txd;
        @(negedge tx_clk);
        #0.5;
        rx_q.push_back({txd, lo});
      end
      else
      begin
        if (in_frame)
        begin
          run_q.push_back(run_len);
          in_frame   = 1'b0;
          seen_frame = 1'b1;
          gap_cnt    = 0;
        end
        gap_cnt++;
      end
    end
  end

  // compare captured bytes against the reference stream
  initial
  begin
    phy_pkg::byte_t      got;
    phy_pkg::byte_t      want;
    eth_pkg::arp_field_e f;
    int                  byte_pos;
    byte_pos = 0;
    forever
    begin
      @(posedge tx_clk);
      while (rx_q.size() > 0)
      begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("byte 0x%0h appeared on txd while no frame was expected", got);
        end
        else
        begin
          want = exp_q.pop_front();
          f    = field_at(byte_pos);
          check_value($sformatf("txd byte %0d (%s)", byte_pos, f.name()), want, got);
          byte_pos = (byte_pos + 1) % frame_len;
        end
      end
    end
  end

  // **************************************************
  // tests
  // **************************************************
  initial
  begin
    int          err_start;
    int          high_cnt;
    int          frames;
    int          gap_base;
    logic [31:0] r0;
    logic [31:0] r1;
    rst_n   = 1'b0;
    enable  = 1'b0;
    src_mac = '0;
    src_ip  = '0;
    dst_ip  = '0;
    repeat (2) @(posedge tx_clk);
    #1;
    rst_n = 1'b1;

    err_start = errors;
    count_high(200, high_cnt);
    check_value("tx_ctl high cycles while idle", 0, high_cnt);
    report_test(1, "idle after reset", err_start);

    err_start = errors;
    src_mac = 48'h02_00_5E_10_20_30;
    src_ip  = 32'hC0A8_0164;
    dst_ip  = 32'hC0A8_0101;
    for (int i = 0; i < 3; i++)
      queue_frame();  // three identical frames
    enable = 1'b1;
    wait_frames(1, "the first frame");
    report_test(2, "first frame bytes", err_start);

    err_start = errors;
    check_runs(0);
    report_test(3, "frame length", err_start);

    err_start = errors;
    gap_base  = gap_q.size();
    wait_frames(3, "repeated frames");
    check_runs(1);
    check_value("gaps between frames", 2, gap_q.size() - gap_base);
    for (int i = gap_base; i < gap_q.size(); i++)
      if (gap_q[i] < gap_len)
      begin
        errors++;
        $display("idle gap of %0d cycles is shorter than %0d", gap_q[i], gap_len);
      end
    report_test(4, "repeated frames and gaps", err_start);

    err_start = errors;
    for (int i = 0; i < 3; i++)
    begin
      r0      = $random(seed);
      r1      = $random(seed);
      src_mac = {r0[15:0], r1};
      src_ip  = $random(seed);
      dst_ip  = $random(seed);
      queue_frame();
      frames = run_q.size();
      enable = 1'b1;
      wait_tx_start();
      enable = 1'b0;
      wait_frames(frames + 1, "a random address frame");
      check_runs(frames);
    end
    report_test(5, "random address frames", err_start);

    err_start = errors;
    src_mac = 48'h02_00_5E_AA_BB_CC;
    src_ip  = 32'h0A00_0005;
    dst_ip  = 32'h0A00_00FE;
    queue_frame();
    frames = run_q.size();
    enable = 1'b1;
    wait_tx_start();
    repeat (30) next_cycle();
    enable = 1'b0;  // mid frame
    wait_frames(frames + 1, "the interrupted frame");
    check_runs(frames);
    count_high(200, high_cnt);
    check_value("tx_ctl high cycles after enable drop", 0, high_cnt);
    check_value("frames after enable drop", frames + 1, run_q.size());
    report_test(6, "enable drop mid frame", err_start);

    if (exp_q.size() != 0)
    begin
      errors++;
      $display("%0d expected bytes never appeared on txd", exp_q.size());
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- verilog/arp_frame_seq.sv
`timescale 1ns/1ps

`include "arp_tx_consts.svh"

module arp_frame_seq #(
  parameter int gap_cycles = `ARP_GAP_DEFAULT
) (
  input  logic                tx_clk,
  input  logic                rst_n,
  input  logic                enable,
  input  eth_pkg::mac_addr_t  src_mac,
  input  eth_pkg::ipv4_addr_t src_ip,
  input  eth_pkg::ipv4_addr_t dst_ip,
  input  logic [31:0]         fcs,
  output phy_pkg::byte_t      seq_byte,
  output logic                seq_valid,
  output logic                crc_init,
  output logic                crc_en
);

  // counter must reach the pad length and the gap length
  localparam int cnt_w = (gap_cycles > 32) ? $clog2(gap_cycles + 1) : 6;

  localparam int hdr_bytes = 42;  // 14 eth + 28 arp
  localparam int fcs_len = `ARP_FRAME_BYTES - `ARP_PREAMBLE_BYTES - 1 - hdr_bytes
                         - `ARP_PAD_BYTES;

  localparam logic [15:0] ethertype = `ARP_ETHERTYPE;
  localparam logic [63:0] arp_hdr   = {`ARP_HTYPE, `ARP_PTYPE, `ARP_HLEN, `ARP_PLEN,
                                       `ARP_OPER_REQ};

  eth_pkg::arp_field_e state;
  logic [cnt_w-1:0]    cnt;
  logic [2:0]          byte_idx;
  logic                last;

  // **************************************************
  // field lengths and order
  // **************************************************
  function automatic int field_len(input eth_pkg::arp_field_e f);
    case (f)
      eth_pkg::st_preamble:  return `ARP_PREAMBLE_BYTES;
      eth_pkg::st_sfd:       return 1;
      eth_pkg::st_dst_mac:   return 6;
      eth_pkg::st_src_mac:   return 6;
      eth_pkg::st_ethertype: return 2;
      eth_pkg::st_arp_hdr:   return 8;
      eth_pkg::st_sender_hw: return 6;
      eth_pkg::st_sender_ip: return 4;
      eth_pkg::st_target_hw: return 6;
      eth_pkg::st_target_ip: return 4;
      eth_pkg::st_pad:       return `ARP_PAD_BYTES;
      eth_pkg::st_fcs:       return fcs_len;
      eth_pkg::st_gap:       return gap_cycles;
      default:               return 1;
    endcase
  endfunction

  function automatic eth_pkg::arp_field_e next_field(input eth_pkg::arp_field_e f);
    case (f)
      eth_pkg::st_preamble:  return eth_pkg::st_sfd;
      eth_pkg::st_sfd:       return eth_pkg::st_dst_mac;
      eth_pkg::st_dst_mac:   return eth_pkg::st_src_mac;
      eth_pkg::st_src_mac:   return eth_pkg::st_ethertype;
      eth_pkg::st_ethertype: return eth_pkg::st_arp_hdr;
      eth_pkg::st_arp_hdr:   return eth_pkg::st_sender_hw;
      eth_pkg::st_sender_hw: return eth_pkg::st_sender_ip;
      eth_pkg::st_sender_ip: return eth_pkg::st_target_hw;
      eth_pkg::st_target_hw: return eth_pkg::st_target_ip;
      eth_pkg::st_target_ip: return eth_pkg::st_pad;
      eth_pkg::st_pad:       return eth_pkg::st_fcs;
      eth_pkg::st_fcs:       return eth_pkg::st_gap;
      default:               return eth_pkg::st_idle;
    endcase
  endfunction

  assign last     = (int'(cnt) == field_len(state) - 1);
  assign byte_idx = cnt[2:0];  // widest indexed field is 8 bytes

  // **************************************************
  // state and byte counter
  // **************************************************
  always_ff @(posedge tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= eth_pkg::st_idle;
      cnt   <= '0;
    end
    else if (state == eth_pkg::st_idle)
    begin
      cnt <= '0;
      if (enable)
        state <= eth_pkg::st_preamble;
    end
    else if (last)
    begin
      cnt   <= '0;
      state <= next_field(state);  // a started frame always finishes
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  // **************************************************
  // byte select with msb first except the fcs
  // **************************************************
  always_comb
  begin
    case (state)
      eth_pkg::st_preamble:  seq_byte = `ARP_PREAMBLE;
      eth_pkg::st_sfd:       seq_byte = `ARP_SFD;
      eth_pkg::st_dst_mac:   seq_byte = 8'hFF;
      eth_pkg::st_src_mac:   seq_byte = src_mac[8*(5-byte_idx) +: 8];
      eth_pkg::st_ethertype: seq_byte = ethertype[8*(1-byte_idx) +: 8];
      eth_pkg::st_arp_hdr:   seq_byte = arp_hdr[8*(7-byte_idx) +: 8];
      eth_pkg::st_sender_hw: seq_byte = src_mac[8*(5-byte_idx) +: 8];
      eth_pkg::st_sender_ip: seq_byte = src_ip[8*(3-byte_idx) +: 8];
      eth_pkg::st_target_ip: seq_byte = dst_ip[8*(3-byte_idx) +: 8];
      eth_pkg::st_fcs:       seq_byte = fcs[8*byte_idx +: 8];  // lsb first
      default:               seq_byte = 8'h00;  // target hw, pad, idle
    endcase
  end

  assign seq_valid = !(state inside {eth_pkg::st_idle, eth_pkg::st_gap});
  assign crc_init  = (state == eth_pkg::st_sfd);
  assign crc_en    = state inside {[eth_pkg::st_dst_mac : eth_pkg::st_pad]};

endmodule

//--- verilog/arp_tx_top.sv
`timescale 1ns/1ps

`include "arp_tx_consts.svh"

module arp_tx_top #(
  parameter int gap_cycles = `ARP_GAP_DEFAULT
) (
  input  logic                tx_clk,
  input  logic                rst_n,
  input  logic                enable,
  input  eth_pkg::mac_addr_t  src_mac,
  input  eth_pkg::ipv4_addr_t src_ip,
  input  eth_pkg::ipv4_addr_t dst_ip,
  output phy_pkg::nibble_t    txd,
  output logic                tx_ctl
);

  phy_pkg::byte_t seq_byte;
  logic           seq_valid;
  logic           crc_init;
  logic           crc_en;
  logic [31:0]    fcs;

  // frame byte stream
  arp_frame_seq #(
    .gap_cycles (gap_cycles)
  ) u_seq (
    .tx_clk    (tx_clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .src_mac   (src_mac),
    .src_ip    (src_ip),
    .dst_ip    (dst_ip),
    .fcs       (fcs),
    .seq_byte  (seq_byte),
    .seq_valid (seq_valid),
    .crc_init  (crc_init),
    .crc_en    (crc_en)
  );

  crc32_eth u_crc (
    .tx_clk   (tx_clk),
    .rst_n    (rst_n),
    .crc_init (crc_init),
    .crc_en   (crc_en),
    .data_in  (seq_byte),
    .fcs      (fcs)
  );

  // pins lag the sequencer by one cycle
  rgmii_ddr_tx u_ddr (
    .tx_clk   (tx_clk),
    .rst_n    (rst_n),
    .byte_in  (seq_byte),
    .valid_in (seq_valid),
    .txd      (txd),
    .tx_ctl   (tx_ctl)
  );

endmodule

//--- verilog/crc32_eth.sv
`timescale 1ns/1ps

module crc32_eth (
  input  logic           tx_clk,
  input  logic           rst_n,
  input  logic           crc_init,
  input  logic           crc_en,
  input  phy_pkg::byte_t data_in,
  output logic [31:0]    fcs
);

  localparam logic [31:0] poly = 32'hEDB8_8320;  // reflected 0x04C11DB7

  logic [31:0] crc_q;

  // one byte lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input phy_pkg::byte_t d);
    logic [31:0] r;
    r = crc ^ {24'h0, d};
    for (int i = 0; i < 8; i++)
    begin
      if (r[0])
        r = (r >> 1) ^ poly;
      else
        r = r >> 1;
    end
    return r;
  endfunction

  always_ff @(posedge tx_clk or negedge rst_n)
  begin
    if (!rst_n)
      crc_q <= '1;
    else if (crc_init)
      crc_q <= '1;
    else if (crc_en)
      crc_q <= crc_byte(crc_q, data_in);
  end

  // reflected register sends its low byte first
  assign fcs = ~crc_q;

endmodule

//--- verilog/eth_pkg.sv
package eth_pkg;

  // **************************************************
  // addresses
  // **************************************************
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;

  // **************************************************
  // sequencer fields in wire order
  // **************************************************
  typedef enum logic [3:0] {
    st_idle      = 4'd0,
    st_preamble  = 4'd1,
    st_sfd       = 4'd2,
    st_dst_mac   = 4'd3,   // broadcast
    st_src_mac   = 4'd4,
    st_ethertype = 4'd5,
    st_arp_hdr   = 4'd6,   // htype, ptype, hlen, plen, oper
    st_sender_hw = 4'd7,
    st_sender_ip = 4'd8,
    st_target_hw = 4'd9,   // unknown and sent as zero
    st_target_ip = 4'd10,
    st_pad       = 4'd11,
    st_fcs       = 4'd12,
    st_gap       = 4'd13
  } arp_field_e;

endpackage

//--- verilog/phy_pkg.sv
package phy_pkg;

  // one byte per tx_clk on the mac side
  typedef logic [7:0] byte_t;

  // half a byte per clock edge on the rgmii pins
  typedef logic [3:0] nibble_t;

endpackage

//--- verilog/rgmii_ddr_tx.sv
`timescale 1ns/1ps

module rgmii_ddr_tx (
  input  logic             tx_clk,
  input  logic             rst_n,
  input  phy_pkg::byte_t   byte_in,
  input  logic             valid_in,
  output phy_pkg::nibble_t txd,
  output logic             tx_ctl
);

  phy_pkg::byte_t byte_q;
  logic           valid_q;

  // output register on the rising edge
  always_ff @(posedge tx_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      byte_q  <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      byte_q  <= byte_in;
      valid_q <= valid_in;
    end
  end

  // **************************************************
  // ddr mux with the low nibble in the high phase
  // **************************************************
  assign txd    = tx_clk ? byte_q[3:0] : byte_q[7:4];
  assign tx_ctl = valid_q;  // tx_er held low so both edges carry tx_en

endmodule
